/* fetch_pkg.sv */
package fetch_pkg;

    // datapath widths
    localparam int xlen = 32;
    localparam int id_width = 64;

    // first fetch address and pc step
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    localparam logic [xlen-1:0] inst_bytes = 32'd4;

    typedef enum logic [1:0] {
        wait_ready,
        wait_valid,
        fetched_wait_move
    } fetch_state_t;

    // source of the request address
    typedef enum logic [1:0] {
        sel_pc,
        sel_next,
        sel_target
    } pc_sel_t;

    typedef struct packed {
        logic            start;
        logic [xlen-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic            ready;
        logic [xlen-1:0] data;
        logic            data_valid;
    } mem_rsp_t;

    typedef struct packed {
        logic            hazard;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                valid;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     inst;
        logic [id_width-1:0] inst_id;
    } fetch_out_t;

endpackage

/* isa_pkg.sv */
package isa_pkg;

    // one rv32i word, read as i-type or as s/b-type
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0]  imm_hi;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } s;
    } inst_word_u;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef enum logic [2:0] {
        alu,
        load,
        store,
        branch,
        jump,
        upper,
        illegal
    } inst_class_t;

    typedef struct packed {
        inst_class_t inst_class;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
    } predecode_t;

endpackage

/* fetch_ctrl.sv */
`timescale 1ns/10ps

module fetch_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_ready,
    input  logic               mem_data_valid,
    input  logic               stall,
    input  logic               hazard,
    output logic               start,
    output logic               advance,
    output logic               redirect_take,
    output logic               capture,
    output logic               use_held,
    output logic               valid,
    output fetch_pkg::pc_sel_t pc_sel
);
    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t state_next;
    logic         delivered;

    // word arrives for the request in flight, not dropped by a redirect
    assign delivered = (state == wait_valid) && mem_data_valid && !hazard;

    assign advance       = delivered;
    assign redirect_take = hazard;
    // only a stalled delivery needs the copy
    assign capture       = delivered && stall;
    assign use_held      = (state == fetched_wait_move);
    assign valid         = !hazard && (delivered || use_held);

    always_comb begin
        start      = 1'b0;
        pc_sel     = sel_pc;
        state_next = state;
        if (hazard) begin
            // restart at the target, the item in flight is dropped
            start      = 1'b1;
            pc_sel     = sel_target;
            state_next = mem_ready ? wait_valid : wait_ready;
        end else begin
            case (state)
                wait_ready: begin
                    start = 1'b1;
                    if (mem_ready) begin
                        state_next = wait_valid;
                    end
                end
                wait_valid: begin
                    pc_sel = sel_next;
                    if (mem_data_valid) begin
                        // next request overlaps this delivery
                        start = !stall;
                        if (stall) begin
                            state_next = fetched_wait_move;
                        end else begin
                            state_next = mem_ready ? wait_valid : wait_ready;
                        end
                    end
                end
                fetched_wait_move: begin
                    // pc already points past the held word
                    start = !stall;
                    if (!stall) begin
                        state_next = mem_ready ? wait_valid : wait_ready;
                    end
                end
                default: begin
                    state_next = wait_ready;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= wait_ready;
        end else begin
            state <= state_next;
        end
    end

    a_no_valid_on_hazard: assert property (
        @(posedge clk) disable iff (!rst_n) hazard |-> !valid
    );

    a_start_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(start)
    );

endmodule

/* pc_gen.sv */
`timescale 1ns/10ps

module pc_gen (
    input  logic                           clk,
    input  logic                           rst_n,
    input  fetch_pkg::pc_sel_t             pc_sel,
    input  logic                           advance,
    input  logic                           redirect_take,
    input  logic [fetch_pkg::xlen-1:0]     target,
    output logic [fetch_pkg::xlen-1:0]     addr,
    output logic [fetch_pkg::xlen-1:0]     pc,
    output logic [fetch_pkg::id_width-1:0] inst_id
);
    import fetch_pkg::*;

    logic [xlen-1:0] pc_next;

    assign pc_next = pc + inst_bytes;

    always_comb begin
        case (pc_sel)
            sel_next:   addr = pc_next;
            sel_target: addr = target;
            default:    addr = pc;
        endcase
    end

    // id steps on every new fetch attempt, so redirects get fresh ids too
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= reset_pc;
            inst_id <= '0;
        end else if (redirect_take) begin
            pc      <= target;
            inst_id <= inst_id + 1'b1;
        end else if (advance) begin
            pc      <= pc_next;
            inst_id <= inst_id + 1'b1;
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    );

endmodule

/* fetch_hold.sv */
`timescale 1ns/10ps

module fetch_hold (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           capture,
    input  logic                           use_held,
    input  logic [fetch_pkg::xlen-1:0]     live_pc,
    input  logic [fetch_pkg::xlen-1:0]     live_inst,
    input  logic [fetch_pkg::id_width-1:0] live_id,
    output logic [fetch_pkg::xlen-1:0]     pc,
    output logic [fetch_pkg::xlen-1:0]     inst,
    output logic [fetch_pkg::id_width-1:0] inst_id
);
    import fetch_pkg::*;

    logic [xlen-1:0]     held_pc;
    logic [xlen-1:0]     held_inst;
    logic [id_width-1:0] held_id;

    always_ff @(posedge clk) begin
        if (capture) begin
            held_pc   <= live_pc;
            held_inst <= live_inst;
            held_id   <= live_id;
        end
    end

    assign pc      = use_held ? held_pc   : live_pc;
    assign inst    = use_held ? held_inst : live_inst;
    assign inst_id = use_held ? held_id   : live_id;

    // decode must see the same item for the whole stall
    a_held_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        use_held ##1 use_held |-> $stable({held_pc, held_inst, held_id})
    );

endmodule

/* inst_predecode.sv */
`timescale 1ns/10ps

module inst_predecode (
    input  logic [31:0]         inst,
    output isa_pkg::predecode_t pre
);
    import isa_pkg::*;

    inst_word_u w;

    assign w = inst;

    // register fields go out raw, decode ignores the ones a format lacks
    assign pre.rd  = w.i.rd;
    assign pre.rs1 = w.i.rs1;
    assign pre.rs2 = w.s.rs2;

    always_comb begin
        case (w.i.opcode)
            op_imm, op_load: begin
                pre.inst_class = (w.i.opcode == op_load) ? load : alu;
                pre.imm        = {{20{w.i.imm[11]}}, w.i.imm};
            end
            op_reg: begin
                pre.inst_class = alu;
                pre.imm        = '0;
            end
            op_store: begin
                pre.inst_class = store;
                pre.imm        = {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
            end
            op_branch: begin
                pre.inst_class = branch;
                pre.imm        = {{19{w.s.imm_hi[6]}}, w.s.imm_hi[6], w.s.imm_lo[0],
                                  w.s.imm_hi[5:0], w.s.imm_lo[4:1], 1'b0};
            end
            op_jalr: begin
                pre.inst_class = jump;
                pre.imm        = {{20{w.i.imm[11]}}, w.i.imm};
            end
            op_jal: begin
                // j-type bits scattered over the i-type fields
                pre.inst_class = jump;
                pre.imm        = {{11{w.i.imm[11]}}, w.i.imm[11], w.i.rs1, w.i.funct3,
                                  w.i.imm[0], w.i.imm[10:1], 1'b0};
            end
            op_lui, op_auipc: begin
                pre.inst_class = upper;
                pre.imm        = {w.i.imm, w.i.rs1, w.i.funct3, 12'b0};
            end
            default: begin
                pre.inst_class = illegal;
                pre.imm        = '0;
            end
        endcase
    end

endmodule

/* fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    output fetch_pkg::mem_req_t   mem_req,
    input  fetch_pkg::mem_rsp_t   mem_rsp,
    input  fetch_pkg::redirect_t  redirect,
    input  logic                  stall,
    output fetch_pkg::fetch_out_t fetch_out,
    output isa_pkg::predecode_t   pre
);
    import fetch_pkg::*;

    pc_sel_t             pc_sel;
    logic                start;
    logic                advance;
    logic                redirect_take;
    logic                capture;
    logic                use_held;
    logic                out_valid;
    logic [xlen-1:0]     req_addr;
    logic [xlen-1:0]     cur_pc;
    logic [id_width-1:0] cur_id;
    logic [xlen-1:0]     out_pc;
    logic [xlen-1:0]     out_inst;
    logic [id_width-1:0] out_id;

    assign mem_req   = '{start: start, addr: req_addr};
    assign fetch_out = '{valid: out_valid, pc: out_pc, inst: out_inst, inst_id: out_id};

    fetch_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_ready      (mem_rsp.ready),
        .mem_data_valid (mem_rsp.data_valid),
        .stall          (stall),
        .hazard         (redirect.hazard),
        .start          (start),
        .advance        (advance),
        .redirect_take  (redirect_take),
        .capture        (capture),
        .use_held       (use_held),
        .valid          (out_valid),
        .pc_sel         (pc_sel)
    );

    pc_gen u_pc (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc_sel        (pc_sel),
        .advance       (advance),
        .redirect_take (redirect_take),
        .target        (redirect.target),
        .addr          (req_addr),
        .pc            (cur_pc),
        .inst_id       (cur_id)
    );

    fetch_hold u_hold (
        .clk       (clk),
        .rst_n     (rst_n),
        .capture   (capture),
        .use_held  (use_held),
        .live_pc   (cur_pc),
        .live_inst (mem_rsp.data),
        .live_id   (cur_id),
        .pc        (out_pc),
        .inst      (out_inst),
        .inst_id   (out_id)
    );

    inst_predecode u_predecode (
        .inst (out_inst),
        .pre  (pre)
    );

endmodule

/* tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model (
    input  logic                clk,
    input  logic                rst_n,
    input  fetch_pkg::mem_req_t req,
    output fetch_pkg::mem_rsp_t rsp
);
    import fetch_pkg::*;

    localparam logic [31:0] lcg_seed = 32'h031b3077;

    // whole stimulus file, only the image at 0x00 is kept
    logic [31:0] image [0:255];
    logic [31:0] mem [0:63];
    logic [31:0] seed;
    logic        busy;
    logic [1:0]  wait_left;
    logic [5:0]  word_idx;
    logic        data_valid;
    logic        accept;

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        $readmemh("fetch_stimulus.txt", image);
        for (int i = 0; i < 64; i++) begin
            mem[i] = image[i];
        end
    end

    assign data_valid = busy && (wait_left == 2'd0);
    // ready again in the cycle that returns data
    assign rsp = '{ready: !busy || data_valid,
                   data: data_valid ? mem[word_idx] : 32'h0,
                   data_valid: data_valid};
    assign accept = req.start && rsp.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seed      <= lcg_seed;
            busy      <= 1'b0;
            wait_left <= 2'd0;
            word_idx  <= '0;
        end else if (accept) begin
            // latency of 1 to 3 cycles
            seed      <= lcg_next(seed);
            busy      <= 1'b1;
            wait_left <= 2'(seed[31:16] % 3);
            word_idx  <= req.addr[7:2];
        end else if (busy) begin
            if (wait_left == 2'd0) begin
                busy <= 1'b0;
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule

/* tb_fetch_unit.sv */
`timescale 1ns/10ps

module tb_fetch_unit;
    import fetch_pkg::*;
    import isa_pkg::*;

    localparam int timeout_cycles = 600;
    // word offsets of the tables in the stimulus file
    localparam int redir_base = 64;
    localparam int stall_base = 80;
    localparam int exp_base = 96;

    logic        clk;
    logic        rst_n;
    logic        stall;
    redirect_t   redirect;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    fetch_out_t  fetch_out;
    predecode_t  pre;

    logic [31:0] stim [0:255];
    int          n_acc;
    int          redir_idx;
    int          stall_idx;
    int          stall_left;
    int          cycles_out_of_reset;
    logic        was_held;
    logic        target_due;
    logic [31:0] due_target;
    logic [63:0] last_id;
    fetch_out_t  prev_out;

    fetch_unit dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .redirect  (redirect),
        .stall     (stall),
        .fetch_out (fetch_out),
        .pre       (pre)
    );

    tb_mem_model mem0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    // rv32i immediate formats taken straight from the raw bit positions
    function automatic predecode_t expected_predecode(input logic [31:0] w);
        predecode_t p;
        p.rd  = w[11:7];
        p.rs1 = w[19:15];
        p.rs2 = w[24:20];
        p.imm = 32'h0;
        case (w[6:0])
            op_reg:    p.inst_class = alu;
            op_imm:    begin
                p.inst_class = alu;
                p.imm        = {{20{w[31]}}, w[31:20]};
            end
            op_load:   begin
                p.inst_class = load;
                p.imm        = {{20{w[31]}}, w[31:20]};
            end
            op_jalr:   begin
                p.inst_class = jump;
                p.imm        = {{20{w[31]}}, w[31:20]};
            end
            op_store:  begin
                p.inst_class = store;
                p.imm        = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            op_branch: begin
                p.inst_class = branch;
                p.imm        = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            op_jal:    begin
                p.inst_class = jump;
                p.imm        = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            op_lui, op_auipc: begin
                p.inst_class = upper;
                p.imm        = {w[31:12], 12'h000};
            end
            default:   p.inst_class = illegal;
        endcase
        return p;
    endfunction

    task automatic check_accepted();
        logic [31:0] exp_pc;
        logic [31:0] inst_word;
        predecode_t  exp_pre;
        exp_pc    = stim[exp_base + 1 + n_acc];
        inst_word = stim[exp_pc[7:2]];
        exp_pre   = expected_predecode(inst_word);
        check_value(fetch_out.pc, exp_pc, "accepted pc");
        check_value(fetch_out.inst, inst_word, "accepted instruction word");
        if (target_due) begin
            check_value(fetch_out.pc, due_target, "first pc after redirect");
            target_due = 1'b0;
        end
        if (n_acc > 0) begin
            check_value(fetch_out.inst_id > last_id, 1'b1, "inst_id not increasing");
        end
        last_id = fetch_out.inst_id;
        check_value(pre.inst_class, exp_pre.inst_class, "predecode class");
        check_value(pre.rd, exp_pre.rd, "predecode rd");
        check_value(pre.rs1, exp_pre.rs1, "predecode rs1");
        check_value(pre.rs2, exp_pre.rs2, "predecode rs2");
        check_value(pre.imm, exp_pre.imm, "predecode imm");
        n_acc++;
    endtask

    // redirect and stall events keyed on the number of accepted items
    always @(posedge clk) begin
        if (rst_n) begin
            if (redir_idx < stim[redir_base] && n_acc == stim[redir_base + 1 + 2 * redir_idx]) begin
                redirect <= '{hazard: 1'b1, target: stim[redir_base + 2 + 2 * redir_idx]};
                redir_idx++;
            end else begin
                redirect.hazard <= 1'b0;
            end
            if (stall_left > 0) begin
                stall <= 1'b1;
                stall_left--;
            end else if (stall_idx < stim[stall_base]
                         && n_acc == stim[stall_base + 1 + 2 * stall_idx]) begin
                stall      <= 1'b1;
                stall_left = stim[stall_base + 2 + 2 * stall_idx] - 1;
                stall_idx++;
            end else begin
                stall <= 1'b0;
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst_n || cycles_out_of_reset == 0) begin
            check_value(fetch_out.valid, 1'b0, "valid high during or just after reset");
            check_value(mem_req.addr, reset_pc, "first request address");
            check_value(mem_req.start, 1'b1, "first request start");
        end
        if (rst_n) begin
            cycles_out_of_reset++;
            if (redirect.hazard) begin
                check_value(fetch_out.valid, 1'b0, "valid high while hazard is high");
                check_value(mem_req.start, 1'b1, "no restart request on redirect");
                check_value(mem_req.addr, redirect.target, "restart address on redirect");
                target_due = 1'b1;
                due_target = redirect.target;
            end
            if (was_held && stall && !redirect.hazard) begin
                check_value(fetch_out.valid, 1'b1, "valid dropped during stall");
                check_value(mem_req.start, 1'b0, "new request issued during stall");
                check_value(fetch_out.pc, prev_out.pc, "pc changed during stall");
                check_value(fetch_out.inst, prev_out.inst, "inst changed during stall");
                check_value(fetch_out.inst_id, prev_out.inst_id, "inst_id changed during stall");
            end
            was_held = fetch_out.valid && stall;
            prev_out = fetch_out;
            if (fetch_out.valid && !stall && n_acc < stim[exp_base]) begin
                check_accepted();
            end
        end
    end

    initial begin
        int wait_cycles;
        clk        = 1'b0;
        rst_n      = 1'b0;
        stall      = 1'b0;
        redirect   = '0;
        was_held   = 1'b0;
        target_due = 1'b0;
        due_target = 32'h0;
        last_id    = 64'h0;
        $readmemh("fetch_stimulus.txt", stim);
        check_value($isunknown(stim[exp_base]), 1'b0, "stimulus file not read");
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        wait_cycles = 0;
        while (n_acc < stim[exp_base] && wait_cycles < timeout_cycles) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (n_acc < stim[exp_base]) begin
            $display("timeout waiting for accepted items: got %0d of %0d in %0d cycles",
                     n_acc, stim[exp_base], wait_cycles);
            stop_with_failure();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* fetch_stimulus.txt */
// hex words for $readmemh, 0x00: instruction memory image, 64 words
// 0x40: redirect count, then pairs of accepted-item count and target
// 0x50: stall count, then pairs of start item and length; 0x60: pc count, then expected pcs
@00
FFF00093 12345137 FF812183 FE312E23 00308233 FE2088E3 00600013 00700013
FEDFF0EF 00C08067 FFFFF297 FFFFFFFF 00C00013 00D00013 00E00013 00F00013
7FF50513 80052593 40A58633 00061463 00C502A3 FFF60683 01600013 01700013
01800013 01900013 01A00013 01B00013 01C00013 01D00013 01E00013 01F00013
80000063 0010006F 80000FB7 7FF0AFA3 005373B3 02500013 02600013 02700013
02800013 02900013 02A00013 02B00013 02C00013 02D00013 02E00013 02F00013
03000013 03100013 03200013 03300013 03400013 03500013 03600013 03700013
03800013 03900013 03A00013 03B00013 03C00013 03D00013 03E00013 03F00013
@40
3
06 40
0C 20
10 80
@50
3
03 05
09 04
12 06
@60
15
00 04 08 0C 10 14
40 44 48 4C 50 54
20 24 28 2C
80 84 88 8C 90

/* flist.f */
fetch_pkg.sv
isa_pkg.sv
fetch_ctrl.sv
pc_gen.sv
fetch_hold.sv
inst_predecode.sv
fetch_unit.sv
tb_mem_model.sv
tb_fetch_unit.sv

/* Bender.yml */
package:
  name: fetch_unit

sources:
  - files:
      - fetch_pkg.sv
      - isa_pkg.sv
      - fetch_ctrl.sv
      - pc_gen.sv
      - fetch_hold.sv
      - inst_predecode.sv
      - fetch_unit.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_fetch_unit.sv
